// ==== hw/dcache_pkg.sv ====
////////////////////////////////////////
// Data cache shared definitions
// Widths, memory latency, bus commands and the bus structs
////////////////////////////////////////

`default_nettype none

package dcache_pkg;

	////////////////////////////////////////
	// Cache geometry
	////////////////////////////////////////
	localparam int DCACHE_IDX_BITS = 5;
	localparam int DCACHE_TAG_BITS = 8;
	localparam int DCACHE_LINES    = 1 << DCACHE_IDX_BITS;
	localparam int LINE_ADDR_BITS  = DCACHE_IDX_BITS + DCACHE_TAG_BITS; // Tag and index together

	////////////////////////////////////////
	// Memory
	////////////////////////////////////////
	localparam int MEM_ADDR_BITS  = 16;                // Byte address bits that are decoded
	localparam int MEM_WADDR_BITS = MEM_ADDR_BITS - 3; // Word address
	localparam int MEM_WORDS      = 1 << MEM_WADDR_BITS;
	localparam int MEM_TAG_BITS   = 4;                 // Tag 0 means no transaction
	localparam int MEM_TAG_MAX    = (1 << MEM_TAG_BITS) - 1;
	localparam int MEM_LATENCY    = 8;                 // Below MEM_TAG_MAX, so no tag reuse in flight

	typedef enum logic [1:0] {
		BUS_NONE  = 2'h0,
		BUS_LOAD  = 2'h1,
		BUS_STORE = 2'h2
	} bus_cmd_e;

	typedef struct packed {
		bus_cmd_e    cmd;
		logic [63:0] addr;
		logic [63:0] data;
	} proc_req_t;

	typedef struct packed {
		logic                    accepted; // Cleared when a refill takes the cycle
		logic                    valid;
		logic [MEM_TAG_BITS-1:0] tag;
		logic [63:0]             data;
	} proc_resp_t;

	typedef struct packed {
		bus_cmd_e    cmd;
		logic [63:0] addr; // Word aligned
		logic [63:0] data;
	} mem_req_t;

	typedef struct packed {
		logic [MEM_TAG_BITS-1:0] response; // Tag granted to this cycle's load
		logic [MEM_TAG_BITS-1:0] tag;      // Nonzero with refill data
		logic [63:0]             data;
	} mem_resp_t;

	typedef struct packed {
		logic                       en;
		logic [DCACHE_IDX_BITS-1:0] idx;
		logic [DCACHE_TAG_BITS-1:0] tag;
		logic [63:0]                data;
	} array_wr_t;

endpackage

`default_nettype wire

// ==== hw/dcache_array.sv ====
////////////////////////////////////////
// Direct-mapped cache storage
// Valid, tag and one data word per line
////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module dcache_array
	import dcache_pkg::*;
(
	input  wire logic                       clock,
	input  wire logic                       reset,
	input  wire logic [DCACHE_IDX_BITS-1:0] rd_idx,
	input  wire logic [DCACHE_TAG_BITS-1:0] rd_tag,
	input  wire array_wr_t                  array_wr,
	output logic      [63:0]                rd_data,
	output logic                            rd_hit
);

	logic [DCACHE_LINES-1:0]    line_vld;
	logic [DCACHE_TAG_BITS-1:0] line_tag  [DCACHE_LINES];
	logic [63:0]                line_data [DCACHE_LINES];

	// Combinational lookup
	assign rd_data = line_data[rd_idx];
	assign rd_hit  = line_vld[rd_idx] && (line_tag[rd_idx] == rd_tag);

	always_ff @(posedge clock) begin
		if (reset) begin
			line_vld <= '0;
		end else if (array_wr.en) begin
			line_vld[array_wr.idx] <= 1'b1;
		end
	end

	// Whole line replaced on every write
	always_ff @(posedge clock) begin
		if (array_wr.en) begin
			line_tag[array_wr.idx]  <= array_wr.tag;
			line_data[array_wr.idx] <= array_wr.data;
		end
	end

endmodule

`default_nettype wire

// ==== hw/dcache_ctrl.sv ====
////////////////////////////////////////
// Data cache controller
// Lookup, miss tracking by memory tag, refill and write-through
////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module dcache_ctrl
	import dcache_pkg::*;
(
	input  wire logic                       clock,
	input  wire logic                       reset,
	input  wire proc_req_t                  proc_req,
	input  wire mem_resp_t                  mem_resp,
	input  wire logic [63:0]                rd_data,
	input  wire logic                       rd_hit,
	output proc_resp_t                      proc_resp,
	output mem_req_t                        mem_req,
	output logic      [DCACHE_IDX_BITS-1:0] rd_idx,
	output logic      [DCACHE_TAG_BITS-1:0] rd_tag,
	output array_wr_t                       array_wr
);

	// Miss address table, one slot per memory tag
	logic [LINE_ADDR_BITS-1:0] miss_line [1:MEM_TAG_MAX];
	logic [MEM_TAG_MAX:1]      miss_vld;

	logic [LINE_ADDR_BITS-1:0] req_line;
	logic [LINE_ADDR_BITS-1:0] fill_line;
	logic                      refill;
	logic                      miss_set;

	assign req_line = proc_req.addr[LINE_ADDR_BITS+2:3];
	assign refill   = (mem_resp.tag != '0); // Refill always wins the cycle

	// Line address of the returning load
	assign fill_line = refill ? miss_line[mem_resp.tag] : '0;

	// Lookup follows the processor address
	assign rd_idx = req_line[DCACHE_IDX_BITS-1:0];
	assign rd_tag = req_line[LINE_ADDR_BITS-1:DCACHE_IDX_BITS];

	////////////////////////////////////////
	// Request and refill handling
	////////////////////////////////////////
	always_comb begin
		proc_resp = '0;
		mem_req   = '0;
		array_wr  = '0;
		miss_set  = 1'b0;
		mem_req.cmd = BUS_NONE;

		if (refill) begin
			// Only write lines that a miss actually asked for
			array_wr.en   = miss_vld[mem_resp.tag];
			array_wr.idx  = fill_line[DCACHE_IDX_BITS-1:0];
			array_wr.tag  = fill_line[LINE_ADDR_BITS-1:DCACHE_IDX_BITS];
			array_wr.data = mem_resp.data;
			proc_resp.valid = 1'b1;
			proc_resp.tag   = mem_resp.tag;
			proc_resp.data  = mem_resp.data;
		end else begin
			case (proc_req.cmd)
				BUS_LOAD: begin
					if (rd_hit) begin
						proc_resp.accepted = 1'b1;
						proc_resp.valid    = 1'b1;
						proc_resp.data     = rd_data;
					end else begin
						mem_req.cmd  = BUS_LOAD;
						mem_req.addr = {proc_req.addr[63:3], 3'b000};
						// No grant means the processor has to retry
						proc_resp.accepted = (mem_resp.response != '0);
						proc_resp.tag      = mem_resp.response;
						miss_set           = (mem_resp.response != '0);
					end
				end
				BUS_STORE: begin
					// Write-through with allocate
					array_wr.en   = 1'b1;
					array_wr.idx  = rd_idx;
					array_wr.tag  = rd_tag;
					array_wr.data = proc_req.data;
					mem_req.cmd   = BUS_STORE;
					mem_req.addr  = {proc_req.addr[63:3], 3'b000};
					mem_req.data  = proc_req.data;
					proc_resp.accepted = 1'b1;
				end
				default: ;
			endcase
		end
	end

	////////////////////////////////////////
	// Miss table
	////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			miss_vld <= '0;
		end else if (miss_set) begin
			miss_vld[mem_resp.response] <= 1'b1;
		end else if (refill) begin
			miss_vld[mem_resp.tag] <= 1'b0; // Slot free for the next grant
		end
	end

	always_ff @(posedge clock) begin
		if (miss_set) begin
			miss_line[mem_resp.response] <= req_line;
		end
	end

endmodule

`default_nettype wire

// ==== hw/dmem.sv ====
////////////////////////////////////////
// Tagged data memory
// Non-blocking loads with a fixed latency, immediate stores
////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module dmem
	import dcache_pkg::*;
(
	input  wire logic     clock,
	input  wire logic     reset,
	input  wire mem_req_t mem_req,
	output mem_resp_t     mem_resp
);

	logic [63:0]               mem [MEM_WORDS];
	logic [MEM_TAG_BITS-1:0]   tag_cnt;
	logic [MEM_TAG_BITS-1:0]   pipe_tag  [MEM_LATENCY];
	logic [MEM_WADDR_BITS-1:0] pipe_addr [MEM_LATENCY];
	logic [MEM_WADDR_BITS-1:0] req_waddr;
	logic                      is_load;

	assign req_waddr = mem_req.addr[MEM_ADDR_BITS-1:3];
	assign is_load   = (mem_req.cmd == BUS_LOAD);

	initial begin
		for (int i = 0; i < MEM_WORDS; i++) begin
			mem[i] = '0;
		end
	end

	always_ff @(posedge clock) begin
		if (mem_req.cmd == BUS_STORE) begin
			mem[req_waddr] <= mem_req.data;
		end
	end

	// Grant counter runs 1 to MEM_TAG_MAX
	always_ff @(posedge clock) begin
		if (reset) begin
			tag_cnt <= 1;
		end else if (is_load) begin
			tag_cnt <= (tag_cnt == MEM_TAG_MAX) ? 1 : tag_cnt + 1'b1;
		end
	end

	////////////////////////////////////////
	// Latency pipeline
	////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int s = 0; s < MEM_LATENCY; s++) begin
				pipe_tag[s] <= '0;
			end
		end else begin
			pipe_tag[0] <= is_load ? tag_cnt : '0;
			for (int s = 1; s < MEM_LATENCY; s++) begin
				pipe_tag[s] <= pipe_tag[s-1];
			end
		end
	end

	always_ff @(posedge clock) begin
		pipe_addr[0] <= req_waddr;
		for (int s = 1; s < MEM_LATENCY; s++) begin
			pipe_addr[s] <= pipe_addr[s-1];
		end
	end

	// Data is read as the load leaves, so later stores are seen
	always_comb begin
		mem_resp.response = is_load ? tag_cnt : '0;
		mem_resp.tag      = pipe_tag[MEM_LATENCY-1];
		mem_resp.data     = (pipe_tag[MEM_LATENCY-1] != '0) ? mem[pipe_addr[MEM_LATENCY-1]] : '0;
	end

endmodule

`default_nettype wire

// ==== hw/dcache_top.sv ====
////////////////////////////////////////
// Data cache subsystem
// Controller, cache array and tagged memory
////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module dcache_top
	import dcache_pkg::*;
(
	input  wire logic      clock,
	input  wire logic      reset,
	input  wire proc_req_t proc_req,
	output proc_resp_t     proc_resp
);

	mem_req_t                   mem_req;
	mem_resp_t                  mem_resp;
	logic [DCACHE_IDX_BITS-1:0] rd_idx;
	logic [DCACHE_TAG_BITS-1:0] rd_tag;
	logic [63:0]                rd_data;
	logic                       rd_hit;
	array_wr_t                  array_wr;

	dcache_ctrl u_ctrl (
		.clock     (clock),
		.reset     (reset),
		.proc_req  (proc_req),
		.mem_resp  (mem_resp),
		.rd_data   (rd_data),
		.rd_hit    (rd_hit),
		.proc_resp (proc_resp),
		.mem_req   (mem_req),
		.rd_idx    (rd_idx),
		.rd_tag    (rd_tag),
		.array_wr  (array_wr)
	);

	dcache_array u_array (
		.clock    (clock),
		.reset    (reset),
		.rd_idx   (rd_idx),
		.rd_tag   (rd_tag),
		.array_wr (array_wr),
		.rd_data  (rd_data),
		.rd_hit   (rd_hit)
	);

	dmem u_dmem (
		.clock    (clock),
		.reset    (reset),
		.mem_req  (mem_req),
		.mem_resp (mem_resp)
	);

endmodule

`default_nettype wire

// ==== dv/dcache_checker.sv ====
////////////////////////////////////////
// Controller protocol assertions
// Bound into the cache controller
////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module dcache_checker
	import dcache_pkg::*;
(
	input wire logic       clock,
	input wire logic       reset,
	input wire proc_req_t  proc_req,
	input wire proc_resp_t proc_resp,
	input wire mem_req_t   mem_req,
	input wire mem_resp_t  mem_resp
);

	int unsigned fail_count = 0; // Failed assertions so far

	// Accepted miss carries its grant
	miss_has_tag: assert property (@(posedge clock) disable iff (reset)
		(proc_req.cmd == BUS_LOAD && proc_resp.accepted && !proc_resp.valid)
			|-> (proc_resp.tag != '0))
		else begin
			$error("accepted miss without a memory tag");
			fail_count++;
		end

	valid_has_source: assert property (@(posedge clock) disable iff (reset)
		proc_resp.valid |-> (proc_resp.accepted || proc_resp.tag != '0))
		else begin
			$error("valid response that is neither a hit nor a refill");
			fail_count++;
		end

	// Granted tag comes back after the fixed latency
	refill_on_time: assert property (@(posedge clock) disable iff (reset)
		(mem_req.cmd == BUS_LOAD && mem_resp.response != '0)
			|-> ##MEM_LATENCY (mem_resp.tag == $past(mem_resp.response, MEM_LATENCY)))
		else begin
			$error("refill tag did not return after the memory latency");
			fail_count++;
		end

endmodule

bind dcache_ctrl dcache_checker u_checker (
	.clock     (clock),
	.reset     (reset),
	.proc_req  (proc_req),
	.proc_resp (proc_resp),
	.mem_req   (mem_req),
	.mem_resp  (mem_resp)
);

`default_nettype wire

// ==== dv/dcache_tb.sv ====
////////////////////////////////////////
// Data cache subsystem testbench
// Table-driven loads and stores against a shadow memory
////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module dcache_tb
	import dcache_pkg::*;
();

	typedef enum logic [1:0] {K_HIT, K_MISS, K_STORE} kind_e;

	typedef struct packed {
		logic [2:0]  test;
		bus_cmd_e    cmd;
		logic [63:0] addr;
		logic [63:0] data;
		kind_e       kind;
		logic [3:0]  gap;    // Idle cycles before the request
		logic        refuse; // First attempt lands on a refill
	} entry_t;

	typedef struct packed {
		logic [31:0]             due;
		logic [MEM_TAG_BITS-1:0] tag;
		logic [63:0]             data;
	} refill_t;

	logic        clock;
	logic        reset;
	proc_req_t   proc_req;
	proc_resp_t  proc_resp;
	proc_resp_t  resp;
	entry_t      tbl [$];
	refill_t     pending [$];
	logic [63:0] shadow [logic [MEM_WADDR_BITS-1:0]];
	integer      seed;
	int          cycle_no;
	int          err_count;
	int          tests_failed;
	int          tbl_cycles;
	logic        refill_seen;

	dcache_top dut (
		.clock     (clock),
		.reset     (reset),
		.proc_req  (proc_req),
		.proc_resp (proc_resp)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	function automatic logic [63:0] shadow_rd(input logic [63:0] addr);
		logic [MEM_WADDR_BITS-1:0] w;
		w = addr[MEM_ADDR_BITS-1:3];
		return shadow.exists(w) ? shadow[w] : 64'h0;
	endfunction

	task automatic add_entry(input int test, input bus_cmd_e cmd, input logic [63:0] addr,
			input kind_e kind, input int gap, input logic refuse);
		entry_t e;
		e.test   = test;
		e.cmd    = cmd;
		e.addr   = addr;
		e.data   = {$random(seed), $random(seed)};
		e.kind   = kind;
		e.gap    = gap;
		e.refuse = refuse;
		tbl.push_back(e);
		tbl_cycles += gap + 1;
	endtask

	task automatic report_mismatch(input string name, input logic [63:0] exp, input logic [63:0] got);
		$display("error %s: expected %h, got %h", name, exp, got);
		err_count++;
	endtask

	task automatic report_fault(input string what);
		$display("error: %s", what);
		err_count++;
	endtask

	////////////////////////////////////////
	// One clock cycle with refill checking
	////////////////////////////////////////
	task automatic run_cycle(input bus_cmd_e cmd, input logic [63:0] addr, input logic [63:0] data);
		proc_req_t req;
		req.cmd  = cmd;
		req.addr = addr;
		req.data = data;
		@(posedge clock);
		proc_req <= req;
		cycle_no++;
		@(negedge clock);
		resp        = proc_resp;
		refill_seen = 1'b0;
		if (pending.size() > 0 && pending[0].due == cycle_no) begin
			refill_seen = 1'b1; // Refill owns this cycle
			if (!resp.valid) report_mismatch("proc_resp.valid", 1, resp.valid);
			if (resp.accepted) report_mismatch("proc_resp.accepted", 0, resp.accepted);
			if (resp.tag != pending[0].tag) report_mismatch("proc_resp.tag", pending[0].tag, resp.tag);
			if (resp.data != pending[0].data) begin
				report_mismatch("proc_resp.data", pending[0].data, resp.data);
			end
			void'(pending.pop_front());
		end else if (resp.valid && !resp.accepted) begin
			report_fault("refill arrived with no miss due in this cycle");
		end
	endtask

	task automatic idle_cycle();
		run_cycle(BUS_NONE, 64'h0, 64'h0);
		if (!refill_seen && (resp.valid || resp.accepted)) report_fault("response on an idle cycle");
	endtask

	task automatic apply_entry(input entry_t e);
		logic        refused;
		logic [63:0] exp;
		repeat (e.gap) idle_cycle();
		run_cycle(e.cmd, e.addr, e.data);
		refused = !resp.accepted; // DUT turned the first attempt away
		while (refill_seen) begin
			run_cycle(e.cmd, e.addr, e.data); // Reissue next cycle
		end
		if (refused && !e.refuse) report_fault("request refused where no refill was due");
		if (!refused && e.refuse) report_fault("request not refused during a refill");
		exp = shadow_rd(e.addr);
		if (!resp.accepted) report_mismatch("proc_resp.accepted", 1, resp.accepted);
		case (e.kind)
			K_STORE: begin
				if (resp.valid) report_mismatch("proc_resp.valid", 0, resp.valid);
				shadow[e.addr[MEM_ADDR_BITS-1:3]] = e.data;
			end
			K_HIT: begin
				if (!resp.valid) report_mismatch("proc_resp.valid", 1, resp.valid);
				if (resp.tag != 0) report_mismatch("proc_resp.tag", 0, resp.tag);
				if (resp.data != exp) report_mismatch("proc_resp.data", exp, resp.data);
			end
			default: begin
				if (resp.valid) report_mismatch("proc_resp.valid", 0, resp.valid);
				if (resp.tag == 0) report_fault("miss accepted without a memory tag");
				foreach (pending[i]) begin
					if (pending[i].tag == resp.tag) report_fault("memory tag granted twice in flight");
				end
				pending.push_back('{cycle_no + MEM_LATENCY, resp.tag, exp});
			end
		endcase
	endtask

	task automatic report_test(input int t, input int errs);
		string name;
		case (t)
			1: name = "after reset";
			2: name = "store then load";
			3: name = "cold load miss";
			4: name = "back-to-back misses";
			5: name = "conflict eviction";
			default: name = "request during refill";
		endcase
		if (errs != 0) tests_failed++;
		$display("test %0d %s: %0d errors", t, name, errs);
	endtask

	initial begin
		int limit;
		int t;
		int err_mark;
		reset        = 1'b1;
		proc_req     = '0;
		seed         = 12710;
		cycle_no     = 0;
		err_count    = 0;
		tests_failed = 0;
		tbl_cycles   = 0;

		// Addresses: offset [2:0], index [7:3], tag [15:8]
		add_entry(1, BUS_LOAD,  64'h0100, K_MISS,  2, 1'b0);
		add_entry(1, BUS_LOAD,  64'h0208, K_MISS,  0, 1'b0);
		add_entry(2, BUS_STORE, 64'h0310, K_STORE, 8, 1'b0);
		add_entry(2, BUS_LOAD,  64'h0310, K_HIT,   0, 1'b0);
		add_entry(3, BUS_LOAD,  64'h0418, K_MISS,  0, 1'b0);
		add_entry(3, BUS_LOAD,  64'h0418, K_HIT,   8, 1'b0);
		add_entry(3, BUS_LOAD,  64'h0100, K_HIT,   0, 1'b0);
		add_entry(4, BUS_LOAD,  64'h0520, K_MISS,  0, 1'b0);
		add_entry(4, BUS_LOAD,  64'h0628, K_MISS,  0, 1'b0);
		add_entry(4, BUS_LOAD,  64'h0730, K_MISS,  0, 1'b0);
		add_entry(4, BUS_LOAD,  64'h0628, K_HIT,   8, 1'b0);
		add_entry(5, BUS_STORE, 64'h0838, K_STORE, 0, 1'b0);
		add_entry(5, BUS_STORE, 64'h0938, K_STORE, 0, 1'b0); // Same index, new tag
		add_entry(5, BUS_LOAD,  64'h0838, K_MISS,  0, 1'b0);
		add_entry(5, BUS_LOAD,  64'h0838, K_HIT,   8, 1'b0);
		add_entry(6, BUS_LOAD,  64'h0a40, K_MISS,  0, 1'b0);
		add_entry(6, BUS_LOAD,  64'h0b48, K_MISS,  7, 1'b1);
		add_entry(6, BUS_STORE, 64'h0c50, K_STORE, 7, 1'b1);
		add_entry(6, BUS_LOAD,  64'h0c50, K_HIT,   0, 1'b0);
		add_entry(6, BUS_LOAD,  64'h0b48, K_HIT,   0, 1'b0);

		limit = (tbl_cycles + MEM_LATENCY + 20) * 10 * 2;
		fork
			begin
				#(limit);
				$display("error: run timed out before the tests finished");
				$display("sim failed");
				$finish;
			end
		join_none

		repeat (10) @(posedge clock);
		reset <= 1'b0;

		t        = tbl[0].test;
		err_mark = 0;
		foreach (tbl[i]) begin
			if (tbl[i].test != t) begin
				report_test(t, err_count - err_mark);
				t        = tbl[i].test;
				err_mark = err_count;
			end
			apply_entry(tbl[i]);
		end
		repeat (MEM_LATENCY) idle_cycle();
		if (pending.size() != 0) report_fault("refills still missing at the end of the run");
		if (dut.u_ctrl.u_checker.fail_count != 0) begin
			report_fault("controller protocol assertions failed");
		end
		report_test(t, err_count - err_mark);

		$display("%0d tests, %0d failed, %0d errors", t, tests_failed, err_count);
		if (err_count == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== dcache_top.f ====
hw/dcache_pkg.sv
hw/dcache_array.sv
hw/dcache_ctrl.sv
hw/dmem.sv
hw/dcache_top.sv
dv/dcache_checker.sv
dv/dcache_tb.sv

// ==== Bender.yml ====
package:
  name: dcache

sources:
  - hw/dcache_pkg.sv
  - hw/dcache_array.sv
  - hw/dcache_ctrl.sv
  - hw/dmem.sv
  - hw/dcache_top.sv
  - target: test
    files:
      - dv/dcache_checker.sv
      - dv/dcache_tb.sv
